// File: sim/blit_stimulus.txt
# M addr count words: preload, E addr count words: expected memory, S busy full: status
# B ctrl shift mod_a mod_b val_t mod_d src_a src_b val_c dst_d lines words, R n: wait n blits
# test 1: plain copy
M 100 4 1234 5678 9abc def0
M 200 5 0000 0000 0000 0000 eeee
B 02 ff00 0 0 0 0 0100 ffff 0 0200 0 3
R 1
E 200 5 1234 5678 9abc def0 eeee
S 0 0
T 1
# test 2: logic operation with A and B read, three term selections
M 110 2 f0f0 1234
M 120 2 ff00 5555
B 00 ff00 0 0 6666 0 0110 0120 0f0f 0130 0 1
R 1
B 0c ff00 0 0 6666 0 0110 0120 0f0f 0138 0 1
R 1
B 04 ff00 0 0 6666 0 0110 0120 0f0f 013c 0 1
R 1
E 130 2 ff0f 1f1b
E 138 2 0ff0 4761
E 13c 2 ffff 1d3b
T 2
# test 3: rectangle, incrementing then decrementing
M 140 6 1111 2222 0000 0000 3333 4444
M 152 2 aaaa aaaa
M 16a 2 bbbb bbbb
B 02 ff00 0002 0 0 0002 0140 ffff 0 0150 1 1
R 1
E 150 6 1111 2222 aaaa aaaa 3333 4444
B 12 ff00 fffe 0 0 fffe 0145 ffff 0 016d 1 1
R 1
E 168 6 1111 2222 bbbb bbbb 3333 4444
T 3
# test 4: shift with spill and edge masks
M 180 3 abcd 1234 5678
M 190 3 9999 9999 9999
B 02 7e01 0 0 0 0 0180 ffff 0 0190 0 2
R 1
E 190 3 9abc d123 4569
B 02 ff03 0 0 0 0 0180 ffff 0 0198 0 1
R 1
E 198 2 000a bcd1
T 4
# test 5: transparency, 4 bpp then 8 bpp
M 1a0 2 1234 5678
M 1a8 2 0f00 00f0
M 1b0 2 eeee eeee
M 1b8 2 eeee eeee
B 04 ff00 0 0 0000 0 01a0 01a8 0 01b0 0 1
R 1
B 24 ff00 0 0 0000 0 01a0 01a8 0 01b8 0 1
R 1
E 1b0 2 e2ee ee7e
E 1b8 2 12ee ee78
T 5
# test 6: second blit queued while the first runs
B 02 ff00 fffc 0 0 0 0100 ffff 0 01c0 1 3
F
B 02 ff00 0 0 0 0 0140 ffff 0 01d0 0 1
S 1 1
R 2
S 0 0
E 1c0 8 1234 5678 9abc def0 1234 5678 9abc def0
E 1d0 2 1111 2222
T 6

// File: vlog.f
design/blit_pkg.sv
design/blit_reg_pkg.sv
design/blit_regs.sv
design/blit_operand.sv
design/blit_sequencer.sv
design/blit_result.sv
design/blitter.sv
sim/tb_clock.sv
sim/tb_vram.sv
sim/tb_blitter.sv

// File: run.sh
#!/bin/sh
# build and run the blitter testbench with Verilator
verilator --binary --timing --assert -f vlog.f --top-module tb_blitter -o tb_blitter_sim \
    > build.log 2>&1 && ./obj_dir/tb_blitter_sim > sim.log 2>&1 || true
grep -q "^Done: no errors$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: sim/tb_blitter.sv
`timescale 1ns/100ps

module tb_blitter import blit_pkg::*, blit_reg_pkg::*; ();

    localparam int TIMEOUT = 2000;      // cycles per wait

    logic       clk, reset_i;
    logic       reg_wr_i;
    reg_num_t   reg_num_i;
    word_t      reg_data_i;
    logic       busy_o, full_o, done_o;
    logic       vram_sel_o, vram_wr_o, vram_ack_i;
    addr_t      vram_addr_o;
    mask_t      vram_wr_mask_o;
    word_t      vram_data_o, vram_data_i;
    logic       load;
    word_t      load_addr, load_data;
    int         done_cnt, done_base;    // done pulses seen, done pulses expected so far
    int         errors, test_errors, checks, tests;
    bit         timed_out;

    tb_clock #(.PERIOD(100), .RESET_CYCLES(3)) u_clock (.clk_o(clk), .reset_o(reset_i));

    tb_vram u_vram (
        .clk, .reset_i, .sel_i(vram_sel_o), .wr_i(vram_wr_o), .addr_i(vram_addr_o),
        .wr_mask_i(vram_wr_mask_o), .wr_data_i(vram_data_o), .load_i(load),
        .load_addr_i(load_addr), .load_data_i(load_data), .ack_o(vram_ack_i),
        .rd_data_o(vram_data_i)
    );

    blitter u_blitter (
        .clk, .reset_i, .reg_wr_i, .reg_num_i, .reg_data_i, .busy_o, .full_o, .done_o,
        .vram_sel_o, .vram_wr_o, .vram_addr_o, .vram_wr_mask_o, .vram_data_o,
        .vram_ack_i, .vram_data_i
    );

    always @(posedge clk) begin
        if (reset_i) begin
            done_cnt <= 0;
        end else if (done_o) begin
            done_cnt <= done_cnt + 1;
        end
    end

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        timed_out = 1'b1;
    endtask

    task automatic note_error();
        errors++;
        test_errors++;
    endtask

    // one register write, strobe held for one cycle
    task automatic write_reg(input int num, input word_t data);
        reg_wr_i   = 1'b1;
        reg_num_i  = reg_num_t'(num);
        reg_data_i = data;
        @(posedge clk);
        #10;
        reg_wr_i = 1'b0;
    endtask

    task automatic preload_word(input word_t addr, input word_t data);
        load      = 1'b1;
        load_addr = addr;
        load_data = data;
        @(posedge clk);
        #10;
        load = 1'b0;
    endtask

    task automatic check_word(input word_t addr, input word_t exp);
        word_t got;
        got = u_vram.mem[addr];
        checks++;
        assert (got === exp) else begin
            $display("ERR %0t: mem[%h] is %h, expected %h", $time, addr, got, exp);
            note_error();
        end
    endtask

    task automatic check_status(input logic busy, input logic full);
        checks++;
        assert (busy_o === busy && full_o === full) else begin
            $display("ERR %0t: busy=%b full=%b, expected busy=%b full=%b",
                     $time, busy_o, full_o, busy, full);
            note_error();
        end
    endtask

    // done and the VRAM request stay low while nothing runs
    task automatic check_idle_bus();
        checks++;
        assert (done_o === 1'b0 && vram_sel_o === 1'b0 && vram_wr_o === 1'b0) else begin
            $display("ERR %0t: done=%b sel=%b wr=%b, expected all low",
                     $time, done_o, vram_sel_o, vram_wr_o);
            note_error();
        end
    endtask

    task automatic wait_queue_empty();
        int cyc;
        cyc = 0;
        while (full_o && cyc < TIMEOUT) begin
            @(posedge clk);
            #10;
            cyc++;
        end
        if (full_o) begin
            report_timeout("the queued blit to start");
        end
    endtask

    // wait until n more done pulses have arrived
    task automatic wait_blits(input int n);
        int cyc;
        cyc = 0;
        while (done_cnt - done_base < n && cyc < TIMEOUT) begin
            @(posedge clk);
            #10;
            cyc++;
        end
        if (done_cnt - done_base < n) begin
            report_timeout("the blits to finish");
        end
        done_base = done_base + n;
    endtask

    task automatic run_stimulus();
        int          fd;
        int          rc;
        int          cnt;
        logic [7:0]  cmd;
        logic [31:0] a;
        logic [31:0] v;
        logic [31:0] b;
        logic [8*256-1:0] line;

        fd = $fopen("sim/blit_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open sim/blit_stimulus.txt");
            errors++;
        end else begin
            rc = $fscanf(fd, " %c", cmd);
            while (rc == 1 && !timed_out) begin
                case (cmd)
                    "#": rc = $fgets(line, fd);
                    "B": begin                          // registers 0 to 11 in order
                        for (int r = 0; r < 12; r++) begin
                            rc = $fscanf(fd, "%h", v);
                            write_reg(r, v[15:0]);
                        end
                    end
                    "M", "E": begin
                        rc = $fscanf(fd, "%h %d", a, cnt);
                        for (int i = 0; i < cnt; i++) begin
                            rc = $fscanf(fd, "%h", v);
                            if (cmd == "M") begin
                                preload_word(a[15:0] + 16'(i), v[15:0]);
                            end else begin
                                check_word(a[15:0] + 16'(i), v[15:0]);
                            end
                        end
                    end
                    "S": begin
                        rc = $fscanf(fd, "%d %d", b, v);
                        check_status(b[0], v[0]);
                    end
                    "F": wait_queue_empty();
                    "R": begin
                        rc = $fscanf(fd, "%d", v);
                        wait_blits(int'(v));
                    end
                    "T": begin
                        rc = $fscanf(fd, "%d", v);
                        tests++;
                        if (test_errors == 0) begin
                            $display("test %0d passed", v);
                        end else begin
                            $display("test %0d failed with %0d errors", v, test_errors);
                        end
                        test_errors = 0;
                    end
                    default: begin
                        $display("unknown command in stimulus file");
                        errors++;
                    end
                endcase
                rc = $fscanf(fd, " %c", cmd);
            end
            $fclose(fd);
        end
    endtask

    initial begin
        int cyc;

        reg_wr_i    = 1'b0;
        reg_num_i   = '0;
        reg_data_i  = '0;
        load        = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        done_base   = 0;
        errors      = 0;
        test_errors = 0;
        checks      = 0;
        tests       = 0;
        timed_out   = 1'b0;

        cyc = 0;
        while (reset_i !== 1'b0 && cyc < TIMEOUT) begin
            @(posedge clk);
            cyc++;
        end
        if (reset_i !== 1'b0) begin
            report_timeout("reset to end");
        end else begin
            @(posedge clk);
            #10;
            check_status(1'b0, 1'b0);
            check_idle_bus();
            run_stimulus();
            checks++;
            assert (done_cnt == done_base) else begin
                $display("ERR %0t: %0d done pulses, expected %0d", $time, done_cnt, done_base);
                note_error();
            end
        end

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: sim/tb_vram.sv
`timescale 1ns/100ps

module tb_vram (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        sel_i,
    input  logic        wr_i,
    input  logic [15:0] addr_i,
    input  logic [3:0]  wr_mask_i,
    input  logic [15:0] wr_data_i,
    input  logic        load_i,         // preload port, used while the DUT is idle
    input  logic [15:0] load_addr_i,
    input  logic [15:0] load_data_i,
    output logic        ack_o,
    output logic [15:0] rd_data_o
);

    logic [15:0] mem [0:65535];
    logic        ack_r;
    logic [15:0] rd_r;
    logic [1:0]  dly;
    integer      seed;

    assign #10 ack_o     = ack_r;
    assign #10 rd_data_o = rd_r;

    initial begin
        seed = 32'h1654_a605;
        for (int i = 0; i < 65536; i++) begin
            mem[i] = 16'(i) ^ 16'hc35a;     // background depends on the whole address
        end
    end

    always @(posedge clk) begin
        if (reset_i) begin
            ack_r <= 1'b0;
            dly   <= 2'd0;
        end else if (ack_r) begin
            ack_r <= 1'b0;
            dly   <= 2'($random(seed));     // 0 to 3 extra wait cycles
        end else if (sel_i) begin
            if (dly == 2'd0) begin
                ack_r <= 1'b1;
                rd_r  <= mem[addr_i];
            end else begin
                dly <= dly - 2'd1;
            end
        end
        if (ack_r && sel_i && wr_i) begin
            for (int n = 0; n < 4; n++) begin
                if (wr_mask_i[n]) begin
                    mem[addr_i][n*4 +: 4] <= wr_data_i[n*4 +: 4];
                end
            end
        end
        if (load_i) begin
            mem[load_addr_i] <= load_data_i;
        end
    end

endmodule

// File: sim/tb_clock.sv
`timescale 1ns/100ps

module tb_clock #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 3
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // reset drops a little after the edge, like every other input
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #10 reset_o = 1'b0;
    end

endmodule

// File: design/blitter.sv
`timescale 1ns/100ps

module blitter import blit_pkg::*, blit_reg_pkg::*; #(
    parameter int LINES_W = 15
) (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        reg_wr_i,           // register write strobe
    input  reg_num_t    reg_num_i,
    input  word_t       reg_data_i,
    output logic        busy_o,
    output logic        full_o,             // a blit waits in the queue
    output logic        done_o,
    output logic        vram_sel_o,
    output logic        vram_wr_o,
    output addr_t       vram_addr_o,
    output mask_t       vram_wr_mask_o,
    output word_t       vram_data_o,
    input  logic        vram_ack_i,
    input  word_t       vram_data_i
);

    logic [CTRL_W-1:0]  q_ctrl, ctrl;
    logic [1:0]         q_shift_cnt, shift_cnt;
    mask_t              q_l_mask, q_r_mask, l_mask, r_mask;
    word_t              q_mod_a, q_mod_b, q_mod_d;
    word_t              q_src_a, q_src_b, q_dst_d;
    word_t              q_val_t, q_val_c, q_words;
    logic [LINES_W-1:0] q_lines;
    word_t              val_t, val_c, val_a, val_b;
    logic               queued, take, load, capture_a, capture_b, first, last;

    assign full_o = queued;

    blit_regs #(.LINES_W(LINES_W)) u_regs (
        .clk, .reset_i, .reg_wr_i, .reg_num_i, .reg_data_i, .take_i(take),
        .ctrl_o(q_ctrl), .shift_cnt_o(q_shift_cnt), .l_mask_o(q_l_mask), .r_mask_o(q_r_mask),
        .mod_a_o(q_mod_a), .mod_b_o(q_mod_b), .mod_d_o(q_mod_d), .src_a_o(q_src_a),
        .src_b_o(q_src_b), .dst_d_o(q_dst_d), .val_t_o(q_val_t), .val_c_o(q_val_c),
        .words_o(q_words), .lines_o(q_lines), .queued_o(queued)
    );

    blit_sequencer #(.LINES_W(LINES_W)) u_sequencer (
        .clk, .reset_i, .q_ctrl_i(q_ctrl), .q_shift_cnt_i(q_shift_cnt),
        .q_l_mask_i(q_l_mask), .q_r_mask_i(q_r_mask), .q_mod_a_i(q_mod_a), .q_mod_b_i(q_mod_b),
        .q_mod_d_i(q_mod_d), .q_src_a_i(q_src_a), .q_src_b_i(q_src_b), .q_dst_d_i(q_dst_d),
        .q_val_t_i(q_val_t), .q_val_c_i(q_val_c), .q_words_i(q_words), .q_lines_i(q_lines),
        .queued_i(queued), .vram_ack_i, .take_o(take), .load_o(load),
        .capture_a_o(capture_a), .capture_b_o(capture_b), .ctrl_o(ctrl),
        .shift_cnt_o(shift_cnt), .l_mask_o(l_mask), .r_mask_o(r_mask), .val_t_o(val_t),
        .val_c_o(val_c), .first_o(first), .last_o(last), .vram_sel_o, .vram_wr_o,
        .vram_addr_o, .busy_o, .done_o
    );

    // SRC registers double as the constants
    blit_operand u_operand_a (
        .clk, .reset_i, .load_i(load), .const_i(q_src_a), .capture_i(capture_a),
        .shift_i(shift_cnt), .rd_data_i(vram_data_i), .val_o(val_a)
    );

    blit_operand u_operand_b (
        .clk, .reset_i, .load_i(load), .const_i(q_src_b), .capture_i(capture_b),
        .shift_i(shift_cnt), .rd_data_i(vram_data_i), .val_o(val_b)
    );

    blit_result u_result (
        .ctrl_i(ctrl), .val_a_i(val_a), .val_b_i(val_b), .val_c_i(val_c), .val_t_i(val_t),
        .l_mask_i(l_mask), .r_mask_i(r_mask), .first_i(first), .last_i(last),
        .wr_data_o(vram_data_o), .wr_mask_o(vram_wr_mask_o)
    );

endmodule

// File: design/blit_result.sv
`timescale 1ns/100ps

module blit_result import blit_pkg::*, blit_reg_pkg::*; (
    input  logic [CTRL_W-1:0]   ctrl_i,
    input  word_t               val_a_i,
    input  word_t               val_b_i,
    input  word_t               val_c_i,
    input  word_t               val_t_i,
    input  mask_t               l_mask_i,
    input  mask_t               r_mask_i,
    input  logic                first_i,        // first word of the line
    input  logic                last_i,         // last word of the line
    output word_t               wr_data_o,
    output mask_t               wr_mask_o
);

    word_t  term_b;
    word_t  term_c;
    word_t  diff;           // zero where B matches T
    mask_t  nib_ne;
    mask_t  opaque;

    assign term_b    = ctrl_i[CTRL_B_USE_A] ? val_a_i : val_b_i;
    assign term_c    = ctrl_i[CTRL_C_USE_B] ? val_b_i : val_c_i;
    assign wr_data_o = (val_a_i & term_b) ^ term_c;
    assign diff      = val_b_i ^ val_t_i;

    always_comb begin
        for (int n = 0; n < $bits(mask_t); n++) begin
            nib_ne[n] = |diff[n*NIB_W +: NIB_W];
        end
        for (int n = 0; n < $bits(mask_t); n++) begin
            opaque[n] = ctrl_i[CTRL_TRANSP_8B] ? nib_ne[n] | nib_ne[n ^ 1] : nib_ne[n];  // byte pair
        end
    end

    assign wr_mask_o = opaque & (first_i ? l_mask_i : '1) & (last_i ? r_mask_i : '1);

endmodule

// File: design/blit_sequencer.sv
`timescale 1ns/100ps

module blit_sequencer import blit_pkg::*, blit_reg_pkg::*; #(
    parameter int LINES_W = 15
) (
    input  logic                clk,
    input  logic                reset_i,
    input  logic [CTRL_W-1:0]   q_ctrl_i,
    input  logic [1:0]          q_shift_cnt_i,
    input  mask_t               q_l_mask_i,
    input  mask_t               q_r_mask_i,
    input  word_t               q_mod_a_i,
    input  word_t               q_mod_b_i,
    input  word_t               q_mod_d_i,
    input  word_t               q_src_a_i,
    input  word_t               q_src_b_i,
    input  word_t               q_dst_d_i,
    input  word_t               q_val_t_i,
    input  word_t               q_val_c_i,
    input  word_t               q_words_i,
    input  logic [LINES_W-1:0]  q_lines_i,
    input  logic                queued_i,
    input  logic                vram_ack_i,
    output logic                take_o,
    output logic                load_o,
    output logic                capture_a_o,
    output logic                capture_b_o,
    output logic [CTRL_W-1:0]   ctrl_o,
    output logic [1:0]          shift_cnt_o,
    output mask_t               l_mask_o,
    output mask_t               r_mask_o,
    output word_t               val_t_o,
    output word_t               val_c_o,
    output logic                first_o,
    output logic                last_o,
    output logic                vram_sel_o,
    output logic                vram_wr_o,
    output addr_t               vram_addr_o,
    output logic                busy_o,
    output logic                done_o
);

    typedef enum logic [2:0] {
        S_IDLE, S_SETUP, S_LINE_START, S_RD_A, S_RD_B, S_WR_D, S_LINE_FINISH
    } state_t;

    state_t             state;
    state_t             word_state;         // first access of a word
    addr_t              addr_a, addr_b, addr_d;
    word_t              mod_a, mod_b, mod_d;
    word_t              words_r;
    logic [WORD_W:0]    word_cnt;           // msb set on the last word of a line
    logic [LINES_W:0]   line_cnt;           // msb set on the last line
    logic               last_line;

    function automatic addr_t step(input addr_t a, input logic dec);
        step = dec ? a - 1'b1 : a + 1'b1;
    endfunction

    assign last_line   = line_cnt[LINES_W];
    assign last_o      = word_cnt[WORD_W];
    assign take_o      = (state == S_SETUP);
    assign load_o      = (state == S_SETUP);
    assign capture_a_o = (state == S_RD_A) && vram_ack_i;
    assign capture_b_o = (state == S_RD_B) && vram_ack_i;
    assign busy_o      = (state != S_IDLE);
    assign done_o      = (state == S_LINE_FINISH) && last_line;

    // request fields follow the state, addresses only move on ack
    assign vram_sel_o  = (state == S_RD_A) || (state == S_RD_B) || (state == S_WR_D);
    assign vram_wr_o   = (state == S_WR_D);
    assign vram_addr_o = (state == S_RD_A) ? addr_a : (state == S_RD_B) ? addr_b : addr_d;

    always_comb begin
        if (!ctrl_o[CTRL_A_CONST]) begin
            word_state = S_RD_A;
        end else if (!ctrl_o[CTRL_B_CONST]) begin
            word_state = S_RD_B;
        end else begin
            word_state = S_WR_D;            // both constant, write only
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state  <= S_IDLE;
            ctrl_o <= '0;
        end else begin
            case (state)
                S_IDLE: state <= queued_i ? S_SETUP : S_IDLE;
                S_SETUP: begin
                    ctrl_o <= q_ctrl_i;
                    state  <= S_LINE_START;
                end
                S_LINE_START: state <= word_state;
                S_RD_A: begin
                    if (vram_ack_i) begin
                        state <= ctrl_o[CTRL_B_CONST] ? S_WR_D : S_RD_B;
                    end
                end
                S_RD_B: state <= vram_ack_i ? S_WR_D : S_RD_B;
                S_WR_D: begin
                    if (vram_ack_i) begin
                        state <= last_o ? S_LINE_FINISH : word_state;
                    end
                end
                S_LINE_FINISH: begin
                    if (!last_line) begin
                        state <= S_LINE_START;
                    end else begin
                        state <= queued_i ? S_SETUP : S_IDLE;   // next blit skips idle
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            S_SETUP: begin
                shift_cnt_o <= q_shift_cnt_i;
                l_mask_o    <= q_l_mask_i;
                r_mask_o    <= q_r_mask_i;
                val_t_o     <= q_val_t_i;
                val_c_o     <= q_val_c_i;
                mod_a       <= q_mod_a_i;
                mod_b       <= q_mod_b_i;
                mod_d       <= q_mod_d_i;
                addr_a      <= q_src_a_i;
                addr_b      <= q_src_b_i;
                addr_d      <= q_dst_d_i;
                words_r     <= q_words_i;
                line_cnt    <= {1'b0, q_lines_i};
                first_o     <= 1'b1;
            end
            S_LINE_START: begin
                line_cnt <= line_cnt - 1'b1;            // pre-decrement
                word_cnt <= {1'b0, words_r} - 1'b1;
            end
            S_RD_A: begin
                if (vram_ack_i) begin
                    addr_a <= step(addr_a, ctrl_o[CTRL_DECREMENT]);
                end
            end
            S_RD_B: begin
                if (vram_ack_i) begin
                    addr_b <= step(addr_b, ctrl_o[CTRL_DECREMENT]);
                end
            end
            S_WR_D: begin
                if (vram_ack_i) begin
                    addr_d   <= step(addr_d, ctrl_o[CTRL_DECREMENT]);
                    word_cnt <= word_cnt - 1'b1;
                    first_o  <= 1'b0;
                end
            end
            S_LINE_FINISH: begin
                addr_a  <= addr_a + mod_a;              // line modulo
                addr_b  <= addr_b + mod_b;
                addr_d  <= addr_d + mod_d;
                first_o <= 1'b1;
            end
            default: begin
            end
        endcase
    end

    a_addr_held: assert property (@(posedge clk) disable iff (reset_i)
        vram_sel_o && !vram_ack_i |=> vram_sel_o && $stable(vram_addr_o));

    a_done_pulse: assert property (@(posedge clk) disable iff (reset_i)
        done_o |=> !done_o);

endmodule

// File: design/blit_operand.sv
`timescale 1ns/100ps

module blit_operand import blit_pkg::*; (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        load_i,         // start of blit, value becomes the constant
    input  word_t       const_i,
    input  logic        capture_i,      // read data valid
    input  logic [1:0]  shift_i,        // nibbles to shift right
    input  word_t       rd_data_i,
    output word_t       val_o
);

    logic [SPILL_W-1:0]        spill_r;     // left aligned, oldest nibble on top
    logic [WORD_W+SPILL_W-1:0] shifted;     // result word above the new spill

    always_comb begin
        case (shift_i)
            2'd0: shifted = {rd_data_i, {SPILL_W{1'b0}}};
            2'd1: shifted = {spill_r[SPILL_W-1 -: NIB_W], rd_data_i, {2*NIB_W{1'b0}}};
            2'd2: shifted = {spill_r[SPILL_W-1 -: 2*NIB_W], rd_data_i, {NIB_W{1'b0}}};
            default: shifted = {spill_r, rd_data_i};
        endcase
    end

    always_ff @(posedge clk) begin
        if (load_i) begin
            val_o <= const_i;
        end else if (capture_i) begin
            val_o <= shifted[WORD_W+SPILL_W-1 -: WORD_W];
        end
    end

    // spill is carried from word to word and across lines
    always_ff @(posedge clk) begin
        if (reset_i || load_i) begin
            spill_r <= '0;
        end else if (capture_i) begin
            spill_r <= shifted[SPILL_W-1:0];
        end
    end

endmodule

// File: design/blit_regs.sv
`timescale 1ns/100ps

module blit_regs import blit_pkg::*, blit_reg_pkg::*; #(
    parameter int LINES_W = 15
) (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                reg_wr_i,
    input  reg_num_t            reg_num_i,
    input  word_t               reg_data_i,
    input  logic                take_i,         // sequencer copied the queued set
    output logic [CTRL_W-1:0]   ctrl_o,
    output logic [1:0]          shift_cnt_o,
    output mask_t               l_mask_o,
    output mask_t               r_mask_o,
    output word_t               mod_a_o,
    output word_t               mod_b_o,
    output word_t               mod_d_o,
    output word_t               src_a_o,
    output word_t               src_b_o,
    output word_t               dst_d_o,
    output word_t               val_t_o,
    output word_t               val_c_o,
    output word_t               words_o,
    output logic [LINES_W-1:0]  lines_o,
    output logic                queued_o
);

    // control fields and the queue flag
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ctrl_o      <= '0;
            shift_cnt_o <= '0;
            l_mask_o    <= '0;
            r_mask_o    <= '0;
            queued_o    <= 1'b0;
        end else begin
            if (take_i) begin
                queued_o <= 1'b0;
            end
            if (reg_wr_i) begin
                case (reg_num_i)
                    REG_CTRL: ctrl_o <= reg_data_i[CTRL_W-1:0];
                    REG_SHIFT: begin
                        l_mask_o    <= reg_data_i[SHIFT_L_MASK_LSB +: $bits(mask_t)];
                        r_mask_o    <= reg_data_i[SHIFT_R_MASK_LSB +: $bits(mask_t)];
                        shift_cnt_o <= reg_data_i[SHIFT_CNT_LSB +: 2];
                    end
                    REG_WORDS: queued_o <= 1'b1;      // wins over take_i
                    default: begin
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reg_wr_i) begin
            case (reg_num_i)
                REG_MOD_A: mod_a_o <= reg_data_i;
                REG_MOD_B: mod_b_o <= reg_data_i;
                REG_VAL_T: val_t_o <= reg_data_i;
                REG_MOD_D: mod_d_o <= reg_data_i;
                REG_SRC_A: src_a_o <= reg_data_i;
                REG_SRC_B: src_b_o <= reg_data_i;
                REG_VAL_C: val_c_o <= reg_data_i;
                REG_DST_D: dst_d_o <= reg_data_i;
                REG_LINES: lines_o <= reg_data_i[LINES_W-1:0];
                REG_WORDS: words_o <= reg_data_i;
                default: begin
                end
            endcase
        end
    end

    // the sequencer only takes a blit that is actually queued
    a_take_queued: assert property (@(posedge clk) disable iff (reset_i)
        take_i |-> queued_o);

endmodule

// File: design/blit_reg_pkg.sv
package blit_reg_pkg;

    typedef logic [3:0] reg_num_t;

    localparam reg_num_t REG_CTRL  = 4'd0;
    localparam reg_num_t REG_SHIFT = 4'd1;
    localparam reg_num_t REG_MOD_A = 4'd2;
    localparam reg_num_t REG_MOD_B = 4'd3;
    localparam reg_num_t REG_VAL_T = 4'd4;
    localparam reg_num_t REG_MOD_D = 4'd5;
    localparam reg_num_t REG_SRC_A = 4'd6;     // address, or constant A
    localparam reg_num_t REG_SRC_B = 4'd7;     // address, or constant B
    localparam reg_num_t REG_VAL_C = 4'd8;
    localparam reg_num_t REG_DST_D = 4'd9;
    localparam reg_num_t REG_LINES = 4'd10;    // line count minus one
    localparam reg_num_t REG_WORDS = 4'd11;    // word count minus one, queues the blit

    // CTRL bits
    localparam int CTRL_W         = 6;
    localparam int CTRL_A_CONST   = 0;
    localparam int CTRL_B_CONST   = 1;
    localparam int CTRL_B_USE_A   = 2;
    localparam int CTRL_C_USE_B   = 3;
    localparam int CTRL_DECREMENT = 4;
    localparam int CTRL_TRANSP_8B = 5;

    // SHIFT fields
    localparam int SHIFT_L_MASK_LSB = 12;
    localparam int SHIFT_R_MASK_LSB = 8;
    localparam int SHIFT_CNT_LSB    = 0;

endpackage

// File: design/blit_pkg.sv
package blit_pkg;

    localparam int WORD_W  = 16;                // bits in one VRAM word
    localparam int NIB_W   = 4;                 // one pixel at 4 bpp
    localparam int SPILL_W = WORD_W - NIB_W;    // up to 3 nibbles shifted out

    // one VRAM data word
    typedef logic [WORD_W-1:0] word_t;

    // VRAM word address, same width as a data word
    typedef logic [WORD_W-1:0] addr_t;

    // nibble write enables, msb is the leftmost nibble
    typedef logic [WORD_W/NIB_W-1:0] mask_t;

endpackage
